/* Bender.yml */
package:
  name: board_top

sources:
  - common/board_pkg.sv
  - common/seg_pkg.sv
  - mic/i2s_mic_receiver.sv
  - display/seg_scanner.sv
  - display/static_seg_latch.sv
  - verilog/mic_level_lab.sv
  - verilog/board_top.sv
  - target: simulation
    files:
      - testbench/tb_clock.sv
      - testbench/board_top_tb.sv

/* board_top.f */
common/board_pkg.sv
common/seg_pkg.sv
mic/i2s_mic_receiver.sv
display/seg_scanner.sv
display/static_seg_latch.sv
verilog/mic_level_lab.sv
verilog/board_top.sv
testbench/tb_clock.sv
testbench/board_top_tb.sv

/* common/board_pkg.sv */
// Board widths, I2S mic frame timing and receiver states shared by the wrapper, lab top and receiver
`default_nettype none

package board_pkg;

    //----------------------------------------------------------------------
    // Board resources

    localparam int w_key    = 3;
    localparam int w_sw     = 10;  // Top switch is the reset
    localparam int w_led    = 10;
    localparam int w_sample = 24;  // INMP441 word width

    //----------------------------------------------------------------------
    // I2S frame timing

    localparam int sck_half      = 8;   // clk cycles per sck half period
    localparam int bits_per_half = 32;  // sck periods per ws half

    typedef enum logic [1:0] {
        rx_wait_left,  // Wait for ws to fall
        rx_skip,       // One delay bit before the MSB
        rx_shift,      // Sample bits MSB first
        rx_ignore      // Rest of the left half
    } rx_state_t;

endpackage

`default_nettype wire

/* common/seg_pkg.sv */
// Seven-segment display constants and hex glyph table for the scanner and the static latch
`default_nettype none

package seg_pkg;

    localparam int n_digits    = 4;
    localparam int w_seg       = 8;   // Segments a to g plus the point
    localparam int scan_cycles = 16;  // clk cycles per digit slot

    // abcdefgh patterns, active high, point off
    typedef enum logic [7:0] {
        glyph_0 = 8'b1111_1100,
        glyph_1 = 8'b0110_0000,
        glyph_2 = 8'b1101_1010,
        glyph_3 = 8'b1111_0010,
        glyph_4 = 8'b0110_0110,
        glyph_5 = 8'b1011_0110,
        glyph_6 = 8'b1011_1110,
        glyph_7 = 8'b1110_0000,
        glyph_8 = 8'b1111_1110,
        glyph_9 = 8'b1111_0110,
        glyph_a = 8'b1110_1110,
        glyph_b = 8'b0011_1110,  // Lower case b
        glyph_c = 8'b1001_1100,
        glyph_d = 8'b0111_1010,  // Lower case d
        glyph_e = 8'b1001_1110,
        glyph_f = 8'b1000_1110
    } hex_glyph_t;

    localparam hex_glyph_t glyph_table [16] = '{
        glyph_0, glyph_1, glyph_2, glyph_3, glyph_4, glyph_5, glyph_6, glyph_7,
        glyph_8, glyph_9, glyph_a, glyph_b, glyph_c, glyph_d, glyph_e, glyph_f
    };

endpackage

`default_nettype wire

/* display/seg_scanner.sv */
// Dynamic display driver that scans a 16-bit hex value over one segment bus and a one-hot digit select
`default_nettype none

module seg_scanner
(
    input  wire                            clk,
    input  wire                            rst,
    input  wire  [15:0]                    value,
    output logic [seg_pkg::w_seg-1:0]      abcdefgh,
    output logic [seg_pkg::n_digits-1:0]   digit
);

    import seg_pkg::*;

    logic [$clog2(scan_cycles)-1:0] scan_cnt;
    logic                           advance;
    logic [n_digits-1:0]            next_digit;
    logic [3:0]                     nibble;

    assign advance = (scan_cnt == scan_cycles - 1);

    always_comb
    begin
        next_digit = advance ? {digit[n_digits-2:0], digit[n_digits-1]} : digit;
        nibble     = '0;
        for (int i = 0; i < n_digits; i++)
            if (next_digit[i])
                nibble = value[i*4 +: 4];
    end

    //----------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt <= '0;
            digit    <= n_digits'(1);  // Rightmost digit first
            abcdefgh <= '0;            // All segments dark
        end
        else
        begin
            scan_cnt <= advance ? '0 : scan_cnt + 1'b1;
            digit    <= next_digit;
            if (advance)
                abcdefgh <= glyph_table[nibble];  // New glyph with new digit
        end
    end

endmodule

`default_nettype wire

/* display/static_seg_latch.sv */
// Turns scanned segment and digit signals into sticky active-low registers for a static display
`default_nettype none

module static_seg_latch
(
    input  wire                            clk,
    input  wire                            rst,
    input  wire  [seg_pkg::w_seg-1:0]      abcdefgh,
    input  wire  [seg_pkg::n_digits-1:0]   digit,
    output logic [6:0]                     hex0_d,
    output logic [6:0]                     hex1_d,
    output logic [6:0]                     hex2_d,
    output logic [6:0]                     hex3_d,
    output logic                           hex0_dp,
    output logic                           hex1_dp,
    output logic                           hex2_dp,
    output logic                           hex3_dp
);

    import seg_pkg::*;

    logic [w_seg-1:0] hgfedcba;  // Segment a in bit 0
    logic [6:0]       seg_q [n_digits];
    logic             dp_q  [n_digits];

    always_comb
        for (int i = 0; i < w_seg; i++)
            hgfedcba[i] = abcdefgh[w_seg-1-i];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < n_digits; i++)
            begin
                seg_q[i] <= '1;  // Blank
                dp_q[i]  <= 1'b1;
            end
        end
        else
        begin
            for (int i = 0; i < n_digits; i++)
                if (digit[i])
                begin
                    seg_q[i] <= ~hgfedcba[6:0];
                    dp_q[i]  <= ~hgfedcba[7];
                end
        end
    end

    assign hex0_d  = seg_q[0];
    assign hex1_d  = seg_q[1];
    assign hex2_d  = seg_q[2];
    assign hex3_d  = seg_q[3];
    assign hex0_dp = dp_q[0];
    assign hex1_dp = dp_q[1];
    assign hex2_dp = dp_q[2];
    assign hex3_dp = dp_q[3];

endmodule

`default_nettype wire

/* mic/i2s_mic_receiver.sv */
// I2S master for an INMP441 mic that makes sck and ws and captures the left-channel sample
`default_nettype none

module i2s_mic_receiver
(
    input  wire                             clk,
    input  wire                             rst,
    output logic                            sck,
    output logic                            ws,
    output logic                            lr,
    input  wire                             sd,
    output logic [board_pkg::w_sample-1:0]  sample,
    output logic                            sample_valid
);

    import board_pkg::*;

    logic [$clog2(sck_half)-1:0]      div_cnt;
    logic [$clog2(bits_per_half)-1:0] bit_cnt;
    logic [$clog2(w_sample)-1:0]      bit_idx;
    rx_state_t                        state;
    logic                             sck_rise;
    logic                             sck_fall;
    logic                             half_end;

    assign lr = 1'b0;  // Mic answers in the left slot

    assign sck_rise = (div_cnt == sck_half - 1) && !sck;
    assign sck_fall = (div_cnt == sck_half - 1) && sck;
    assign half_end = sck_fall && (bit_cnt == bits_per_half - 1);

    //----------------------------------------------------------------------
    // sck divider and ws half counter

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            ws      <= 1'b0;
        end
        else
        begin
            if (div_cnt == sck_half - 1)
            begin
                div_cnt <= '0;
                sck     <= ~sck;
            end
            else
                div_cnt <= div_cnt + 1'b1;

            // ws moves on falling sck only
            if (half_end)
            begin
                bit_cnt <= '0;
                ws      <= ~ws;
            end
            else if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // Capture FSM

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state        <= rx_wait_left;
            bit_idx      <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= 1'b0;

            case (state)
                rx_wait_left:
                    if (half_end && ws)  // ws about to fall
                        state <= rx_skip;
                rx_skip:
                    if (sck_rise)
                    begin
                        state   <= rx_shift;
                        bit_idx <= '0;
                    end
                rx_shift:
                    if (sck_rise)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == w_sample - 1)
                        begin
                            state        <= rx_ignore;
                            sample_valid <= 1'b1;
                        end
                    end
                rx_ignore:
                    if (half_end && !ws)  // Right half begins
                        state <= rx_wait_left;
                default:
                    state <= rx_wait_left;
            endcase
        end
    end

    // Shift register doubles as the sample output
    always_ff @(posedge clk)
    begin
        if (state == rx_shift && sck_rise)
            sample <= {sample[w_sample-2:0], sd};
    end

endmodule

`default_nettype wire

/* testbench/board_top_tb.sv */
// Board testbench with an INMP441 model that checks the hex displays, level bar and key freeze
`default_nettype none

module board_top_tb;

    import board_pkg::*;
    import seg_pkg::*;

    localparam int reset_cycles   = 16;
    localparam int frame_cycles   = 2 * bits_per_half * 2 * sck_half;
    localparam int disp_delay     = 2 + n_digits * scan_cycles + 1;
    localparam int timeout_cycles = 20 * frame_cycles + 500;  // 16 frames, start-up and margin
    localparam int n_random       = 10;

    logic                clk;
    logic [w_key-1:0]    button;
    logic [w_sw-1:0]     sw;
    logic [w_led-1:0]    ledg;
    logic [6:0]          hex0_d, hex1_d, hex2_d, hex3_d;
    logic                hex0_dp, hex1_dp, hex2_dp, hex3_dp;
    logic                vga_hs, vga_vs;
    logic [3:0]          vga_r, vga_g, vga_b;
    wire  [31:0]         gpio0_d;
    wire  [31:0]         gpio1_d;
    logic                mic_sd = 1'b0;
    logic                sck_prev = 1'b0;
    logic                ws_prev = 1'b0;
    int                  bit_pos = 0;
    logic [w_sample-1:0] cur_left = '0;
    logic [w_sample-1:0] cur_right = '0;
    logic [w_sample-1:0] next_left = '0;
    logic [w_sample-1:0] next_right = '0;
    logic [w_sample-1:0] sent_q [$];      // Left words in the order they went out
    string               frame_name = "";
    integer              seed = 63;
    int                  frames_checked = 0;
    int                  cycle_cnt = 0;
    bit                  timed_out = 1'b0;
    int                  hex_errors = 0;
    int                  point_errors = 0;
    int                  led_errors = 0;
    int                  pin_errors = 0;
    int                  other_errors = 0;

    assign gpio0_d[7] = mic_sd;  // sd from the mic

    tb_clock clock_i (.clk(clk));

    board_top board_top_i
    (
        .clk     (clk),     .button  (button),  .sw      (sw),      .ledg    (ledg),
        .hex0_d  (hex0_d),  .hex1_d  (hex1_d),  .hex2_d  (hex2_d),  .hex3_d  (hex3_d),
        .hex0_dp (hex0_dp), .hex1_dp (hex1_dp), .hex2_dp (hex2_dp), .hex3_dp (hex3_dp),
        .vga_hs  (vga_hs),  .vga_vs  (vga_vs),
        .vga_r   (vga_r),   .vga_g   (vga_g),   .vga_b   (vga_b),
        .gpio0_d (gpio0_d), .gpio1_d (gpio1_d)
    );

    //----------------------------------------------------------------------
    // Reference functions

    // Active-low pattern with segment a in bit 0
    function automatic logic [6:0] glyph_ref(input logic [3:0] nibble);
        hex_glyph_t g;
        logic [6:0] seg;
        case (nibble)
            4'h0: g = glyph_0;
            4'h1: g = glyph_1;
            4'h2: g = glyph_2;
            4'h3: g = glyph_3;
            4'h4: g = glyph_4;
            4'h5: g = glyph_5;
            4'h6: g = glyph_6;
            4'h7: g = glyph_7;
            4'h8: g = glyph_8;
            4'h9: g = glyph_9;
            4'ha: g = glyph_a;
            4'hb: g = glyph_b;
            4'hc: g = glyph_c;
            4'hd: g = glyph_d;
            4'he: g = glyph_e;
            default: g = glyph_f;
        endcase
        for (int i = 0; i < 7; i++)
            seg[i] = g[7-i];  // a sits in bit 7 of abcdefgh
        return ~seg;
    endfunction

    function automatic logic [w_led-1:0] led_ref(input logic [w_sample-1:0] s);
        int value;
        int magnitude;
        logic [w_led-1:0] bar;
        value     = {{(32 - w_sample){s[w_sample-1]}}, s};
        magnitude = (value < 0) ? -value : value;
        for (int i = 0; i < w_led; i++)
            bar[i] = (magnitude >= (1 << (13 + i)));
        return bar;
    endfunction

    //----------------------------------------------------------------------
    // Compare tasks

    task automatic check_hex(input string name, input logic [6:0] exp, input logic [6:0] act);
        if (act !== exp)
        begin
            hex_errors++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_point(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            point_errors++;
            $display("Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_led(input string name, input logic [w_led-1:0] exp,
                             input logic [w_led-1:0] act);
        if (act !== exp)
        begin
            led_errors++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_outputs(input string tag, input logic [6:0] e0, input logic [6:0] e1,
                                   input logic [6:0] e2, input logic [6:0] e3,
                                   input logic [w_led-1:0] eled);
        check_hex({tag, " hex0"}, e0, hex0_d);
        check_hex({tag, " hex1"}, e1, hex1_d);
        check_hex({tag, " hex2"}, e2, hex2_d);
        check_hex({tag, " hex3"}, e3, hex3_d);
        check_point({tag, " dp0"}, 1'b1, hex0_dp);  // Point always off
        check_point({tag, " dp1"}, 1'b1, hex1_dp);
        check_point({tag, " dp2"}, 1'b1, hex2_dp);
        check_point({tag, " dp3"}, 1'b1, hex3_dp);
        check_led({tag, " led"}, eled, ledg);
    endtask

    task automatic end_run();
        $display("Errors: hex %0d, point %0d, led %0d, pins %0d, other %0d",
                 hex_errors, point_errors, led_errors, pin_errors, other_errors);
        if (!timed_out && hex_errors + point_errors + led_errors + pin_errors + other_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    endtask

    //----------------------------------------------------------------------
    // Mic model, acts one clk after each falling sck

    always @(posedge clk)
    begin
        if (sck_prev && !gpio0_d[6])
        begin
            if (gpio0_d[4] != ws_prev)
            begin
                bit_pos = 0;
                if (!gpio0_d[4])  // Left half starts
                begin
                    cur_left = next_left;
                    sent_q.push_back(next_left);
                end
                else
                    cur_right = next_right;
            end
            else
                bit_pos++;
            ws_prev = gpio0_d[4];
            if (bit_pos >= 1 && bit_pos <= w_sample)  // MSB in the second bit
                mic_sd <= gpio0_d[4] ? cur_right[w_sample-bit_pos] : cur_left[w_sample-bit_pos];
            else
                mic_sd <= 1'b0;
        end
        sck_prev = gpio0_d[6];
    end

    // Mic ground and supply pins
    always @(negedge clk)
        if (gpio0_d[3] !== 1'b0 || gpio0_d[5] !== 1'b1)
        begin
            pin_errors++;
            $display("Error: mic gnd/vdd pins in cycle %0d expected %b actual %b",
                     cycle_cnt, 2'b01, {gpio0_d[3], gpio0_d[5]});
        end

    // Mic channel select, unused VGA outputs and the idle gpio1 header
    always @(negedge clk)
        if (gpio0_d[2] !== 1'b0 || {vga_hs, vga_vs, vga_r, vga_g, vga_b} !== 14'd0
            || gpio1_d !== {32{1'bz}})
        begin
            pin_errors++;
            $display("Error: lr/vga/gpio1 pins in cycle %0d expected %b %h %h actual %b %h %h",
                     cycle_cnt, 1'b0, 14'd0, {32{1'bz}}, gpio0_d[2],
                     {vga_hs, vga_vs, vga_r, vga_g, vga_b}, gpio1_d);
        end

    //----------------------------------------------------------------------
    // Checker follows each sample strobe

    initial
    begin : frame_check
        logic [w_sample-1:0] held_ref;
        logic [w_sample-1:0] word;
        held_ref = '0;
        forever
        begin
            @(posedge clk);
            if (board_top_i.sample_valid === 1'b1)
            begin
                word = held_ref;
                if (sent_q.size() == 0)
                begin
                    other_errors++;
                    $display("Sample strobe came without a left word from the mic");
                end
                else
                    word = sent_q.pop_front();
                if (button[0])  // Released, so the new word is taken
                    held_ref = word;
                repeat (disp_delay) @(posedge clk);
                @(negedge clk);
                compare_outputs(frame_name, glyph_ref(held_ref[11:8]), glyph_ref(held_ref[15:12]),
                                glyph_ref(held_ref[19:16]), glyph_ref(held_ref[23:20]),
                                led_ref(held_ref));
                frames_checked++;
            end
        end
    end

    task automatic play_frame(input string name, input logic [w_sample-1:0] word);
        logic [w_sample-1:0] right;
        int                  target;
        right = w_sample'($random(seed));
        if (right[23:8] == word[23:8])
            right = ~right;  // Right word must never look like the left one
        frame_name = name;
        next_left  = word;
        next_right = right;
        target     = frames_checked + 1;
        wait (frames_checked >= target);
    endtask

    //----------------------------------------------------------------------
    // Stimulus

    initial
    begin : stimulus
        logic [w_sample-1:0] directed [3];
        directed        = '{24'h000000, 24'h800000, 24'h400000};
        button          = '1;  // Buttons idle high
        sw              = '0;
        sw[w_sw-1]      = 1'b1;
        repeat (reset_cycles - 1) @(posedge clk);
        @(negedge clk);
        compare_outputs("in reset", '1, '1, '1, '1, '0);
        @(posedge clk);
        sw[w_sw-1] <= 1'b0;
        @(negedge clk);
        compare_outputs("after reset", '1, '1, '1, '1, '0);
        repeat (400) @(posedge clk);
        @(negedge clk);
        check_led("before first frame led", '0, ledg);

        for (int n = 0; n < n_random; n++)
            play_frame($sformatf("random %0d", n), w_sample'($random(seed)));
        foreach (directed[i])
            play_frame($sformatf("directed %0d", i), directed[i]);

        @(posedge clk);
        button[0] <= 1'b0;  // Freeze
        play_frame("frozen 0", w_sample'($random(seed)));
        play_frame("frozen 1", w_sample'($random(seed)));
        @(posedge clk);
        button[0] <= 1'b1;
        play_frame("released", w_sample'($random(seed)));
        end_run();
    end

    initial
    begin : watchdog
        while (cycle_cnt < timeout_cycles)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        timed_out = 1'b1;
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        end_run();
    end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
// Free-running clock source, instantiated once by the board testbench
`default_nettype none

module tb_clock
#(
    parameter int period = 4
)
(
    output logic clk
);

    initial
        clk = 1'b0;

    always
        #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

/* verilog/board_top.sv */
// Board wrapper that maps pins to reset, keys, the I2S mic header and the four static displays
`default_nettype none

module board_top
(
    input  wire                          clk,
    input  wire  [board_pkg::w_key-1:0]  button,
    input  wire  [board_pkg::w_sw-1:0]   sw,
    output logic [board_pkg::w_led-1:0]  ledg,
    output logic [6:0]                   hex0_d,
    output logic [6:0]                   hex1_d,
    output logic [6:0]                   hex2_d,
    output logic [6:0]                   hex3_d,
    output logic                         hex0_dp,
    output logic                         hex1_dp,
    output logic                         hex2_dp,
    output logic                         hex3_dp,
    output logic                         vga_hs,
    output logic                         vga_vs,
    output logic [3:0]                   vga_r,
    output logic [3:0]                   vga_g,
    output logic [3:0]                   vga_b,
    inout  wire  [31:0]                  gpio0_d,
    inout  wire  [31:0]                  gpio1_d
);

    import board_pkg::*;
    import seg_pkg::*;

    logic                rst;
    logic [w_key-1:0]    key;
    logic [w_sample-1:0] sample;
    logic                sample_valid;
    logic [w_seg-1:0]    abcdefgh;
    logic [n_digits-1:0] digit;
    logic                mic_sck;
    logic                mic_ws;
    logic                mic_lr;

    assign rst = sw[w_sw-1];  // Top switch
    assign key = ~button;     // Buttons are active low

    //----------------------------------------------------------------------
    // Mic header on gpio0

    assign gpio0_d[2] = mic_lr;
    assign gpio0_d[3] = 1'b0;     // Mic ground
    assign gpio0_d[4] = mic_ws;
    assign gpio0_d[5] = 1'b1;     // Mic supply
    assign gpio0_d[6] = mic_sck;

    assign gpio0_d[1:0]  = 'z;
    assign gpio0_d[31:8] = 'z;    // Bit 7 is sd from the mic
    assign gpio1_d       = 'z;

    // No VGA in this lab
    assign vga_hs = 1'b0;
    assign vga_vs = 1'b0;
    assign vga_r  = '0;
    assign vga_g  = '0;
    assign vga_b  = '0;

    //----------------------------------------------------------------------

    i2s_mic_receiver mic_i
    (
        .clk          (clk),
        .rst          (rst),
        .sck          (mic_sck),
        .ws           (mic_ws),
        .lr           (mic_lr),
        .sd           (gpio0_d[7]),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    mic_level_lab lab_i
    (
        .clk          (clk),
        .rst          (rst),
        .key          (key),
        .sample       (sample),
        .sample_valid (sample_valid),
        .led          (ledg),
        .abcdefgh     (abcdefgh),
        .digit        (digit)
    );

    static_seg_latch latch_i
    (
        .clk      (clk),
        .rst      (rst),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .hex0_d   (hex0_d),
        .hex1_d   (hex1_d),
        .hex2_d   (hex2_d),
        .hex3_d   (hex3_d),
        .hex0_dp  (hex0_dp),
        .hex1_dp  (hex1_dp),
        .hex2_dp  (hex2_dp),
        .hex3_dp  (hex3_dp)
    );

endmodule

`default_nettype wire

/* verilog/mic_level_lab.sv */
// Lab top that holds the latest mic sample, shows it in hex and drives a level bar on the LEDs
`default_nettype none

module mic_level_lab
(
    input  wire                             clk,
    input  wire                             rst,
    input  wire  [board_pkg::w_key-1:0]     key,
    input  wire  [board_pkg::w_sample-1:0]  sample,
    input  wire                             sample_valid,
    output logic [board_pkg::w_led-1:0]     led,
    output logic [seg_pkg::w_seg-1:0]       abcdefgh,
    output logic [seg_pkg::n_digits-1:0]    digit
);

    import board_pkg::*;

    logic [w_sample-1:0] held;
    logic [w_sample-1:0] magnitude;  // Unsigned, so the most negative value fits

    //----------------------------------------------------------------------
    // Sample hold, key 0 freezes it

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            held <= '0;
        else if (sample_valid && !key[0])
            held <= sample;
    end

    //----------------------------------------------------------------------
    // Level bar

    always_comb
    begin
        magnitude = held[w_sample-1] ? -held : held;
        // LED 0 lights at 2**13, the top LED at 2**22
        for (int i = 0; i < w_led; i++)
            led[i] = magnitude >= (w_sample'(1) << (w_sample - w_led - 1 + i));
    end

    //----------------------------------------------------------------------

    seg_scanner scanner_i
    (
        .clk      (clk),
        .rst      (rst),
        .value    (held[w_sample-1 -: 16]),  // Upper 16 bits only
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

`default_nettype wire
